// ==== rtl/sata_fis_pkg.sv ====
// FIS word types and dword kind codes shared by the SATA transport FIFOs and their users
package sata_fis_pkg;

    typedef logic [31:0] dword_t;      // one FIS dword
    typedef logic [1:0]  mask_t;       // halfword valid bits, normally 2'b11
    typedef logic [1:0]  fis_kind_t;   // tag stored beside every dword

    // kinds valid in both directions
    localparam fis_kind_t KIND_DATA = 2'd0;   // FIS body or DMA data
    localparam fis_kind_t KIND_HEAD = 2'd1;   // first dword of a FIS

    // host to device only
    localparam fis_kind_t H2D_LAST  = 2'd2;   // final dword, lets the link close the frame

    // device to host only, status word pushed after the last data dword
    localparam fis_kind_t D2H_OK    = 2'd2;   // frame received clean
    localparam fis_kind_t D2H_ERR   = 2'd3;   // frame invalidated by the link

    // one FIFO word, 36 bits, kind in the top bits as on the memory port
    typedef struct packed {
        fis_kind_t kind;   // [35:34]
        mask_t     mask;   // [33:32]
        dword_t    data;   // [31:0]
    } fifo_entry_t;

endpackage

// ==== rtl/fis_fifo_pkg.sv ====
// FIFO geometry and fill thresholds for the h2d and d2h FIS buffers
package fis_fifo_pkg;

    localparam int FIFO_ADDR_WIDTH = 9;   // 512 entries, one 18k block RAM at 36 bits

    typedef logic [FIFO_ADDR_WIDTH-1:0] fifo_addr_t;   // memory address
    typedef logic [FIFO_ADDR_WIDTH:0]   fifo_fill_t;   // 0 .. depth inclusive

    localparam fifo_fill_t FIFO_DEPTH = fifo_fill_t'(1 << FIFO_ADDR_WIDTH);

    // h2d side
    localparam fifo_fill_t H2D_READY_LIMIT = 10'd504;   // host may write below this
    localparam fifo_fill_t XMIT_START_FILL = 10'd64;    // long FIS: request frame early

    // d2h side
    localparam fifo_fill_t D2H_MANY_FILL   = 10'd8;     // burst read worthwhile
    localparam fifo_fill_t D2H_BUSY_FILL   = 10'd448;   // leaves room for link pipeline

endpackage

// ==== rtl/fifo_ctrl.sv ====
// Pointer and fill control for a show-ahead FIFO built on a block RAM with output register
`timescale 1ns/100ps

module fifo_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr,         // push, lost when full
    input  logic                     rd,         // pop, ignored when empty
    output logic                     nempty,     // head entry valid at memory rdata
    output fis_fifo_pkg::fifo_fill_t fill,       // total entries held
    output fis_fifo_pkg::fifo_addr_t waddr,      // memory write address
    output fis_fifo_pkg::fifo_addr_t raddr,      // memory read address
    output logic                     mem_re,     // array -> read latch
    output logic                     mem_regen   // read latch -> output register
);

    fis_fifo_pkg::fifo_fill_t ram_cnt;   // entries not yet read out of the array
    logic                     ramo_full; // read latch holds an entry
    logic                     rreg_full; // output register holds the head
    logic                     wr_ok;     // accepted push
    logic                     rd_ok;     // accepted pop

    // waddr only advances on accepted pushes, so a push while full
    // lands on a free slot and is simply lost
    assign wr_ok = wr && (fill != fis_fifo_pkg::FIFO_DEPTH);
    assign rd_ok = rd && rreg_full;

    // advance latch to output when output is free or being popped
    assign mem_regen = ramo_full && (!rreg_full || rd_ok);
    // refill latch when it is free or moving on
    assign mem_re    = (ram_cnt != '0) && (!ramo_full || mem_regen);

    assign nempty = rreg_full;

    // pointers
    always_ff @(posedge clk) begin
        if (rst) begin
            waddr <= '0;
            raddr <= '0;
        end else begin
            if (wr_ok) begin
                waddr <= waddr + 1'b1;   // wraps at depth
            end
            if (mem_re) begin
                raddr <= raddr + 1'b1;
            end
        end
    end

    // counters, both one cycle behind the event
    always_ff @(posedge clk) begin
        if (rst) begin
            fill    <= '0;
            ram_cnt <= '0;
        end else begin
            fill    <= fill + fis_fifo_pkg::fifo_fill_t'(wr_ok)
                            - fis_fifo_pkg::fifo_fill_t'(rd_ok);
            ram_cnt <= ram_cnt + fis_fifo_pkg::fifo_fill_t'(wr_ok)
                               - fis_fifo_pkg::fifo_fill_t'(mem_re);
        end
    end

    // read pipeline occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            ramo_full <= 1'b0;
            rreg_full <= 1'b0;
        end else begin
            if (mem_re) begin
                ramo_full <= 1'b1;       // new entry in latch
            end else if (mem_regen) begin
                ramo_full <= 1'b0;       // latch drained, nothing behind it
            end

            if (mem_regen) begin
                rreg_full <= 1'b1;       // next head arrives
            end else if (rd_ok) begin
                rreg_full <= 1'b0;       // popped, none waiting
            end
        end
    end

endmodule

// ==== rtl/fifo_mem.sv ====
// Dual-port 512 x 36 FIFO memory, read latch plus output register as in a block RAM
`timescale 1ns/100ps

module fifo_mem (
    input  logic                      clk,
    input  logic                      we,      // write strobe
    input  fis_fifo_pkg::fifo_addr_t  waddr,
    input  sata_fis_pkg::fifo_entry_t wdata,
    input  logic                      re,      // array read enable
    input  logic                      regen,   // output register enable
    input  fis_fifo_pkg::fifo_addr_t  raddr,
    output sata_fis_pkg::fifo_entry_t rdata    // show-ahead head entry
);

    sata_fis_pkg::fifo_entry_t mem [fis_fifo_pkg::FIFO_DEPTH];
    sata_fis_pkg::fifo_entry_t rd_latch;   // first read stage

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (re) begin
            rd_latch <= mem[raddr];   // array output
        end
        if (regen) begin
            rdata <= rd_latch;        // output register
        end
    end

endmodule

// ==== rtl/h2d_frame_ctrl.sv ====
// Requests a link frame once a host FIS is fully or mostly in the h2d FIFO
`timescale 1ns/100ps

module h2d_frame_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr,          // host write into h2d FIFO
    input  sata_fis_pkg::fis_kind_t  wr_kind,     // kind of that write
    input  fis_fifo_pkg::fifo_fill_t fill,        // h2d fill level
    input  logic                     frame_ack,   // link took the request
    output logic                     frame_req,   // level to link
    output logic                     h2d_ready    // host may keep writing
);

    typedef enum logic [1:0] {
        ST_IDLE,      // no FIS started
        ST_PENDING,   // head written, waiting for enough data
        ST_REQUEST    // frame_req raised, waiting for ack
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   head_wr;    // head dword written this cycle
    logic   last_wr;    // closing dword written this cycle
    logic   enough;     // long FIS, start before it is complete

    assign head_wr = wr && (wr_kind == sata_fis_pkg::KIND_HEAD);
    assign last_wr = wr && (wr_kind == sata_fis_pkg::H2D_LAST);
    assign enough  = fill >= fis_fifo_pkg::XMIT_START_FILL;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (head_wr) begin
                    state_nxt = ST_PENDING;
                end
            end
            ST_PENDING: begin
                if (last_wr || enough) begin
                    state_nxt = ST_REQUEST;
                end
            end
            ST_REQUEST: begin
                if (frame_ack) begin
                    state_nxt = ST_IDLE;   // heads seen meanwhile are dropped
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign frame_req = (state == ST_REQUEST);   // one cycle after start condition
    assign h2d_ready = fill < fis_fifo_pkg::H2D_READY_LIMIT;

endmodule

// ==== rtl/d2h_tagger.sv ====
// Tags dwords from the link for the d2h FIFO and appends the end-of-FIS status word
`timescale 1ns/100ps

module d2h_tagger (
    input  logic                      clk,
    input  logic                      rst,
    input  sata_fis_pkg::dword_t      rx_data,
    input  sata_fis_pkg::mask_t       rx_mask,
    input  logic                      rx_valid,     // rx_data strobe
    input  logic                      rx_start,     // new incoming frame
    input  logic                      rx_done,      // frame ended clean
    input  logic                      rx_invalid,   // frame ended with error
    input  fis_fifo_pkg::fifo_fill_t  fill,         // d2h fill level
    output logic                      wr,           // push into d2h FIFO
    output sata_fis_pkg::fifo_entry_t wr_entry,
    output logic                      d2h_many,     // several dwords for host
    output logic                      rx_busy       // back-pressure to link
);

    sata_fis_pkg::fis_kind_t tag;       // kind of next pushed word
    logic                    fis_over;  // push status word this cycle
    logic                    rx_end;

    assign rx_end = rx_done || rx_invalid;

    always_ff @(posedge clk) begin
        if (rst || rx_start) begin
            tag <= sata_fis_pkg::KIND_HEAD;         // next dword opens a FIS
        end else if (rx_end) begin
            // ahead of rx_valid so the status push never goes out as data
            tag <= rx_invalid ? sata_fis_pkg::D2H_ERR : sata_fis_pkg::D2H_OK;
        end else if (rx_valid) begin
            tag <= sata_fis_pkg::KIND_DATA;         // body follows
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fis_over <= 1'b0;
        end else begin
            // only once per FIS, tag leaves KIND_DATA at the end
            fis_over <= rx_end && (tag == sata_fis_pkg::KIND_DATA);
        end
    end

    assign wr = rx_valid || fis_over;

    always_comb begin
        wr_entry.kind = tag;
        wr_entry.mask = rx_mask;   // don't care on the status word
        wr_entry.data = rx_data;   // same
    end

    assign d2h_many = fill >= fis_fifo_pkg::D2H_MANY_FILL;
    assign rx_busy  = fill >= fis_fifo_pkg::D2H_BUSY_FILL;

endmodule

// ==== rtl/sata_fis_buffers.sv ====
// Transport-side FIS buffers between host and SATA link, top level of the design
`timescale 1ns/100ps

module sata_fis_buffers (
    input  logic                      clk,
    input  logic                      rst,
    // host -> device
    input  sata_fis_pkg::fifo_entry_t h2d_entry,
    input  logic                      h2d_valid,    // one write per cycle
    output logic                      h2d_ready,
    // h2d FIFO read side, link
    output sata_fis_pkg::fifo_entry_t tx_entry,
    output logic                      tx_valid,
    input  logic                      tx_strobe,    // link pops one dword
    output logic                      frame_req,
    input  logic                      frame_ack,
    // link receive side
    input  sata_fis_pkg::dword_t      rx_data,
    input  sata_fis_pkg::mask_t       rx_mask,
    input  logic                      rx_valid,
    input  logic                      rx_start,
    input  logic                      rx_done,
    input  logic                      rx_invalid,
    output logic                      rx_busy,
    // device -> host
    output sata_fis_pkg::fifo_entry_t d2h_entry,
    output logic                      d2h_valid,
    output logic                      d2h_many,
    input  logic                      d2h_ready     // host pops one dword
);

    fis_fifo_pkg::fifo_fill_t  h2d_fill;
    fis_fifo_pkg::fifo_addr_t  h2d_waddr;
    fis_fifo_pkg::fifo_addr_t  h2d_raddr;
    logic                      h2d_re;
    logic                      h2d_regen;

    fis_fifo_pkg::fifo_fill_t  d2h_fill;
    fis_fifo_pkg::fifo_addr_t  d2h_waddr;
    fis_fifo_pkg::fifo_addr_t  d2h_raddr;
    logic                      d2h_re;
    logic                      d2h_regen;
    logic                      d2h_wr;        // tagger push
    sata_fis_pkg::fifo_entry_t d2h_wr_entry;

    // host to device path
    fifo_ctrl u_h2d_ctrl (
        .clk       (clk),
        .rst       (rst),
        .wr        (h2d_valid),
        .rd        (tx_strobe),
        .nempty    (tx_valid),      // link sees head dword
        .fill      (h2d_fill),
        .waddr     (h2d_waddr),
        .raddr     (h2d_raddr),
        .mem_re    (h2d_re),
        .mem_regen (h2d_regen)
    );

    fifo_mem u_h2d_mem (
        .clk   (clk),
        .we    (h2d_valid),
        .waddr (h2d_waddr),
        .wdata (h2d_entry),
        .re    (h2d_re),
        .regen (h2d_regen),
        .raddr (h2d_raddr),
        .rdata (tx_entry)
    );

    h2d_frame_ctrl u_frame_ctrl (
        .clk       (clk),
        .rst       (rst),
        .wr        (h2d_valid),
        .wr_kind   (h2d_entry.kind),
        .fill      (h2d_fill),
        .frame_ack (frame_ack),
        .frame_req (frame_req),
        .h2d_ready (h2d_ready)
    );

    // device to host path
    d2h_tagger u_tagger (
        .clk        (clk),
        .rst        (rst),
        .rx_data    (rx_data),
        .rx_mask    (rx_mask),
        .rx_valid   (rx_valid),
        .rx_start   (rx_start),
        .rx_done    (rx_done),
        .rx_invalid (rx_invalid),
        .fill       (d2h_fill),
        .wr         (d2h_wr),
        .wr_entry   (d2h_wr_entry),
        .d2h_many   (d2h_many),
        .rx_busy    (rx_busy)
    );

    fifo_ctrl u_d2h_ctrl (
        .clk       (clk),
        .rst       (rst),
        .wr        (d2h_wr),
        .rd        (d2h_ready),     // ignored while empty
        .nempty    (d2h_valid),
        .fill      (d2h_fill),
        .waddr     (d2h_waddr),
        .raddr     (d2h_raddr),
        .mem_re    (d2h_re),
        .mem_regen (d2h_regen)
    );

    fifo_mem u_d2h_mem (
        .clk   (clk),
        .we    (d2h_wr),
        .waddr (d2h_waddr),
        .wdata (d2h_wr_entry),
        .re    (d2h_re),
        .regen (d2h_regen),
        .raddr (d2h_raddr),
        .rdata (d2h_entry)
    );

endmodule

// ==== tests/sata_fis_buffers_tb.sv ====
// Table-driven testbench for the FIS buffers, with link and host models on both FIFO paths
`timescale 1ns/100ps

module sata_fis_buffers_tb;

    localparam logic [1:0] END_NONE    = 2'd0;   // FIS stops without closing word
    localparam logic [1:0] END_LAST    = 2'd1;   // h2d, final dword tagged LAST
    localparam logic [1:0] END_DONE    = 2'd2;   // d2h, rx_done
    localparam logic [1:0] END_INVALID = 2'd3;   // d2h, rx_invalid
    localparam int         NUM_ROWS    = 7;

    typedef struct packed {
        logic       d2h;      // 1 = device to host
        logic       head;     // h2d only, first dword is a FIS head
        logic [1:0] ending;
        logic       stall;    // consumer holds off until producer is done or busy
        logic [9:0] count;    // payload dwords
    } fis_row_t;

    logic                      clk;
    logic                      rst;
    sata_fis_pkg::fifo_entry_t h2d_entry;
    logic                      h2d_valid;
    logic                      h2d_ready;
    sata_fis_pkg::fifo_entry_t tx_entry;
    logic                      tx_valid;
    logic                      tx_strobe;
    logic                      frame_req;
    logic                      frame_ack;
    sata_fis_pkg::dword_t      rx_data;
    sata_fis_pkg::mask_t       rx_mask;
    logic                      rx_valid;
    logic                      rx_start;
    logic                      rx_done;
    logic                      rx_invalid;
    logic                      rx_busy;
    sata_fis_pkg::fifo_entry_t d2h_entry;
    logic                      d2h_valid;
    logic                      d2h_many;
    logic                      d2h_ready;

    fis_row_t                  fis_rows [NUM_ROWS];
    sata_fis_pkg::fifo_entry_t h2d_exp [$];   // written by host, expected at tx
    sata_fis_pkg::fifo_entry_t d2h_exp [$];   // sent by link, expected at host
    integer                    seed;
    int                        errors;
    int                        checks;
    int                        cycles;
    int                        cycle_limit;
    logic                      writer_done;   // h2d writer finished its row
    logic                      host_hold;     // d2h host model stalled
    logic                      req_early;     // frame_req seen before last write

    sata_fis_buffers u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("TIMEOUT at %0t: run stopped after %0d cycles", $time, cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [35:0] actual,
                               input logic [35:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual,
                     expected);
        end
    endtask

    // host side of h2d, one write per cycle
    task automatic write_h2d(input fis_row_t row);
        sata_fis_pkg::fifo_entry_t e;
        int k;
        req_early = 1'b0;
        for (k = 0; k < row.count; k++) begin
            @(negedge clk);
            if (row.stall) begin
                check_value("h2d_ready", h2d_ready, k < fis_fifo_pkg::H2D_READY_LIMIT);
            end
            if (frame_req) begin
                req_early = 1'b1;
            end
            e.kind = sata_fis_pkg::KIND_DATA;
            if (row.head && k == 0) begin
                e.kind = sata_fis_pkg::KIND_HEAD;
            end else if (row.ending == END_LAST && k == row.count - 1) begin
                e.kind = sata_fis_pkg::H2D_LAST;
            end
            e.mask = 2'b11;
            e.data = $random(seed);
            h2d_entry = e;
            h2d_valid = 1'b1;
            h2d_exp.push_back(e);
        end
        @(negedge clk);
        h2d_valid = 1'b0;
        if (row.stall) begin
            check_value("h2d_ready", h2d_ready, row.count < fis_fifo_pkg::H2D_READY_LIMIT);
        end
        writer_done = 1'b1;
    endtask

    // link side of h2d, acks the frame request then pops every dword
    task automatic read_tx(input fis_row_t row);
        sata_fis_pkg::fifo_entry_t e;
        int got;
        got = 0;
        while (row.stall && !writer_done) begin
            @(negedge clk);
        end
        if (row.head) begin
            while (!frame_req) begin
                @(negedge clk);
            end
            repeat (3) @(negedge clk);   // link latency before ack
            frame_ack = 1'b1;
            @(negedge clk);
            frame_ack = 1'b0;
            check_value("frame_req", frame_req, 1'b0);
        end
        while (got < row.count) begin
            @(negedge clk);
            if (tx_valid) begin
                e = h2d_exp.pop_front();
                check_value("tx_entry", tx_entry, e);
                tx_strobe = 1'b1;
                got++;
            end else begin
                tx_strobe = 1'b0;
            end
        end
        @(negedge clk);
        tx_strobe = 1'b0;
        check_value("tx_valid", tx_valid, 1'b0);
        check_value("h2d_ready", h2d_ready, 1'b1);
        check_value("frame_req", frame_req, 1'b0);
    endtask

    // link side of d2h, pauses on rx_busy
    task automatic send_rx(input fis_row_t row);
        sata_fis_pkg::fifo_entry_t e;
        int k;
        k = 0;
        @(negedge clk);
        rx_start = 1'b1;
        @(negedge clk);
        rx_start = 1'b0;
        while (k < row.count) begin
            if (host_hold) begin   // fill equals dwords sent so far
                check_value("d2h_many", d2h_many, k >= fis_fifo_pkg::D2H_MANY_FILL);
                check_value("rx_busy", rx_busy, k >= fis_fifo_pkg::D2H_BUSY_FILL);
                if (k >= fis_fifo_pkg::D2H_BUSY_FILL) begin
                    host_hold = 1'b0;   // let the host drain
                end
            end
            if (rx_busy) begin
                rx_valid = 1'b0;
            end else begin
                e.kind = (k == 0) ? sata_fis_pkg::KIND_HEAD : sata_fis_pkg::KIND_DATA;
                e.mask = 2'b11;
                e.data = $random(seed);
                rx_data = e.data;
                rx_mask = e.mask;
                rx_valid = 1'b1;
                d2h_exp.push_back(e);
                k++;
            end
            @(negedge clk);
        end
        rx_valid = 1'b0;
        host_hold = 1'b0;
        e.kind = (row.ending == END_INVALID) ? sata_fis_pkg::D2H_ERR : sata_fis_pkg::D2H_OK;
        e.mask = 2'b11;
        e.data = '0;
        d2h_exp.push_back(e);
        rx_done = (row.ending != END_INVALID);
        rx_invalid = (row.ending == END_INVALID);
        @(negedge clk);
        rx_done = 1'b0;
        rx_invalid = 1'b0;
    endtask

    // host side of d2h, expects payload plus one status word
    task automatic read_d2h(input fis_row_t row);
        sata_fis_pkg::fifo_entry_t e;
        int got;
        int total;
        got = 0;
        total = row.count + 1;
        while (got < total) begin
            @(negedge clk);
            if (!host_hold && d2h_valid) begin
                e = d2h_exp.pop_front();
                if (got == total - 1) begin
                    check_value("d2h_entry.kind", d2h_entry.kind, e.kind);   // status only
                end else begin
                    check_value("d2h_entry", d2h_entry, e);
                end
                d2h_ready = 1'b1;
                got++;
            end else begin
                d2h_ready = 1'b0;
            end
        end
        @(negedge clk);
        d2h_ready = 1'b0;
        check_value("d2h_valid", d2h_valid, 1'b0);
        check_value("d2h_many", d2h_many, 1'b0);
        check_value("rx_busy", rx_busy, 1'b0);
    endtask

    initial begin
        fis_row_t row;
        rst = 1'b1;
        h2d_entry = '0;
        h2d_valid = 1'b0;
        tx_strobe = 1'b0;
        frame_ack = 1'b0;
        rx_data = '0;
        rx_mask = 2'b11;
        rx_valid = 1'b0;
        rx_start = 1'b0;
        rx_done = 1'b0;
        rx_invalid = 1'b0;
        d2h_ready = 1'b0;
        seed = 26;
        errors = 0;
        checks = 0;
        writer_done = 1'b0;
        host_hold = 1'b0;
        req_early = 1'b0;

        //              d2h   head  ending       stall count
        fis_rows[0] = '{1'b0, 1'b1, END_LAST,    1'b0, 10'd10};    // short FIS with LAST
        fis_rows[1] = '{1'b0, 1'b1, END_NONE,    1'b1, 10'd71};    // long FIS, early request
        fis_rows[2] = '{1'b0, 1'b0, END_NONE,    1'b1, 10'd504};   // no head, fills to limit
        fis_rows[3] = '{1'b1, 1'b0, END_DONE,    1'b0, 10'd20};
        fis_rows[4] = '{1'b1, 1'b0, END_INVALID, 1'b0, 10'd15};
        fis_rows[5] = '{1'b1, 1'b0, END_DONE,    1'b1, 10'd460};   // host stalled to rx_busy
        fis_rows[6] = '{1'b0, 1'b1, END_LAST,    1'b1, 10'd40};

        cycle_limit = 2000;
        for (int i = 0; i < NUM_ROWS; i++) begin
            cycle_limit += 40 * fis_rows[i].count;
        end

        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("frame_req", frame_req, 1'b0);
        check_value("tx_valid", tx_valid, 1'b0);
        check_value("d2h_valid", d2h_valid, 1'b0);
        check_value("d2h_many", d2h_many, 1'b0);
        check_value("rx_busy", rx_busy, 1'b0);
        check_value("h2d_ready", h2d_ready, 1'b1);

        for (int i = 0; i < NUM_ROWS; i++) begin
            row = fis_rows[i];
            writer_done = 1'b0;
            host_hold = row.d2h && row.stall;
            if (!row.d2h) begin
                fork
                    write_h2d(row);
                    read_tx(row);
                join
                // only a long headed FIS may start before its last word
                check_value("frame_req_early", req_early, row.head && row.ending == END_NONE
                            && row.count > fis_fifo_pkg::XMIT_START_FILL + 1);
            end else begin
                fork
                    send_rx(row);
                    read_d2h(row);
                join
            end
        end

        $display("Summary: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sata_fis_buffers.f ====
rtl/sata_fis_pkg.sv
rtl/fis_fifo_pkg.sv
rtl/fifo_ctrl.sv
rtl/fifo_mem.sv
rtl/h2d_frame_ctrl.sv
rtl/d2h_tagger.sv
rtl/sata_fis_buffers.sv
tests/sata_fis_buffers_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := sata_fis_buffers_tb
FILELIST  := sata_fis_buffers.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)
LOG       := sim.log
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
